/* Makefile */
TOP = decodeStageTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f -o simv

run: compile
	./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* dv/decodeStageSva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage assertions
// stall hold, bubble insert, reset pc
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "decode_config.svh"

module decodeStageSva
	import isaPkg::*, pipePkg::*;
(
	input logic     clk,
	input logic     reset,
	input logic     stall,
	input logic     clear,
	input logic     exception,
	input word_t    instrEx,
	input control_t controlEx,
	input word_t    rsEx,
	input word_t    rtEx,
	input word_t    copEx,
	input word_t    nextPc
);
	// whole stage frozen
	holdOnStall: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable(instrEx) && $stable(controlEx) && $stable(rsEx)
			&& $stable(rtEx) && $stable(copEx) && $stable(nextPc))
		else $error("Ex outputs moved during stall");

	bubbleAfterFlush: assert property (@(posedge clk) disable iff (reset)
		(!stall && (clear || exception)) |=> instrEx == '0)
		else $error("instrEx not zero after bubble");

	pcAfterReset: assert property (@(posedge clk)
		reset |=> nextPc == `RESET_ADDRESS)
		else $error("nextPc not at reset address");
endmodule

bind decodeStage decodeStageSva i_sva (
	.clk       (clk),
	.reset     (reset),
	.stall     (stall),
	.clear     (clear),
	.exception (exception),
	.instrEx   (instrEx),
	.controlEx (controlEx),
	.rsEx      (rsEx),
	.rtEx      (rtEx),
	.copEx     (copEx),
	.nextPc    (nextPc)
);

/* dv/decodeStageTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage testbench
// random stimulus, shadow model, checks on Ex outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "decode_config.svh"

module decodeStageTb
	import isaPkg::*, pipePkg::*;
();
	typedef struct packed {
		control_t control;
		word_t    rs;
		word_t    rt;
		word_t    cop;
		word_t    target;
		word_t    nextPc;  // fetch address after the edge
		logic     exception;
	} result_t;

	typedef struct packed {
		word_t    instr;
		control_t control;
		word_t    rs;
		word_t    rt;
		word_t    cop;
		word_t    target;
		word_t    nextPc;
	} exOut_t;

	logic clk;
	logic reset;
	logic stall;
	logic clear;
	logic irq;
	irqNum_t irqNumber;
	word_t instr;
	wbWrite_t wb;
	logic exception;
	control_t controlDe;
	exOut_t dutEx;

	// shadow of the stage state
	word_t shRegs [31:0];
	word_t shCause;
	word_t shStatus;
	word_t shEpc;
	word_t shDecodePc;
	word_t shNextPc;
	logic shPrevBranch;

	exOut_t expNext;  // Ex outputs after next edge
	exOut_t expNow;
	control_t expDe;
	logic expExc;
	logic checkNow;
	logic deCheck;
	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	int cycleCount;

	funct_t fnList [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT, FN_SLL, FN_JR, FN_JALR};
	opcode_t opList [16] = '{OP_SPECIAL, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ,
		OP_BGTZ, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI, OP_COP0, OP_LW, OP_SW};
	opcode_t brList [7] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM, OP_J, OP_JAL};

	decodeStage i_dut (
		.clk            (clk),
		.reset          (reset),
		.stall          (stall),
		.clear          (clear),
		.irq            (irq),
		.irqNumber      (irqNumber),
		.instr          (instr),
		.wb             (wb),
		.exception      (exception),
		.controlDe      (controlDe),
		.instrEx        (dutEx.instr),
		.controlEx      (dutEx.control),
		.rsEx           (dutEx.rs),
		.rtEx           (dutEx.rt),
		.copEx          (dutEx.cop),
		.branchTargetEx (dutEx.target),
		.nextPc         (dutEx.nextPc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t randomBits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic word_t encodeR(funct_t fn, regNum_t rs, regNum_t rt, regNum_t rd);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t encodeMfc0(regNum_t rt, regNum_t rd);
		return {OP_COP0, RS_MFC0, rt, rd, 11'd0};
	endfunction

	function automatic wbWrite_t makeRegWrite(regNum_t num, word_t data);
		return '{regEn: 1'b1, copEn: 1'b0, num: num, data: data};
	endfunction

	function automatic wbWrite_t makeCopWrite(regNum_t num, word_t data);
		return '{regEn: 1'b0, copEn: 1'b1, num: num, data: data};
	endfunction

	// random fields around a fixed opcode with some fields steered to legal codes
	function automatic word_t makeInstr(opcode_t op);
		word_t v;
		v = {op, 26'(randomBits(26))};
		case (op)
			OP_SPECIAL: v[5:0] = fnList[randomBits(3)];
			OP_REGIMM:  v[20:16] = 5'(randomBits(1));  // bltz or bgez
			OP_COP0: begin
				v[25:21] = randomBits(1) != 0 ? RS_MTC0 : RS_MFC0;
				v[15:11] = 5'(randomBits(2));
			end
			OP_BEQ: if (randomBits(1) != 0) v[20:16] = v[25:21];  // equal operands
			default: ;
		endcase
		return v;
	endfunction

	function automatic word_t readShadow(regNum_t num, wbWrite_t w);
		if (num == 5'd0)
			return '0;
		if (w.regEn && w.num == num)
			return w.data;
		return shRegs[num];
	endfunction

	// expected decode result from the shadow state before the edge
	function automatic result_t expectDecode(word_t ins, logic stl, logic clr, logic irqIn,
			wbWrite_t w);
		result_t r;
		opcode_t op;
		funct_t fn;
		word_t pc4;
		logic taken;
		op = opcode_t'(ins[31:26]);
		fn = funct_t'(ins[5:0]);
		r = '0;
		case (op)
			OP_SPECIAL: begin
				r.control.destReg = ins[15:11];
				r.control.flags.regWrite = 1'b1;
				case (fn)
					FN_ADDU: r.control.aluOp = ALU_ADD;
					FN_SUBU: r.control.aluOp = ALU_SUB;
					FN_AND:  r.control.aluOp = ALU_AND;
					FN_OR:   r.control.aluOp = ALU_OR;
					FN_SLT:  r.control.aluOp = ALU_SLT;
					FN_SLL:  r.control.aluOp = ALU_SLL;
					FN_JR, FN_JALR: begin
						r.control.flags.regWrite = fn == FN_JALR;
						r.control.flags.link = fn == FN_JALR;
						r.control.flags.jumpReg = 1'b1;
						r.control.branchType = BR_JUMP;
					end
					default: r.control = '0;
				endcase
			end
			OP_REGIMM: begin
				if (ins[20:16] == 5'd0 || ins[20:16] == 5'd1) begin
					r.control.flags.signExt = 1'b1;
					r.control.branchType = ins[16] ? BR_GEZ : BR_LTZ;
				end
			end
			OP_J: r.control.branchType = BR_JUMP;
			OP_JAL: begin
				r.control.branchType = BR_JUMP;
				r.control.flags.link = 1'b1;
				r.control.flags.regWrite = 1'b1;
				r.control.destReg = 5'd31;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				r.control.flags.signExt = 1'b1;
				r.control.branchType = op == OP_BEQ ? BR_EQ : op == OP_BNE ? BR_NE
					: op == OP_BLEZ ? BR_LEZ : BR_GTZ;
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
				r.control.flags.regWrite = 1'b1;
				r.control.flags.aluSrcImm = 1'b1;
				r.control.destReg = ins[20:16];
				r.control.flags.signExt = op == OP_ADDIU || op == OP_SLTI || op == OP_LW;
				r.control.flags.memRead = op == OP_LW;
				r.control.aluOp = op == OP_SLTI ? ALU_SLT : op == OP_ANDI ? ALU_AND
					: op == OP_ORI ? ALU_OR : op == OP_LUI ? ALU_LUI : ALU_ADD;
			end
			OP_SW: begin
				r.control.flags.memWrite = 1'b1;
				r.control.flags.aluSrcImm = 1'b1;
				r.control.flags.signExt = 1'b1;
				r.control.aluOp = ALU_ADD;
			end
			OP_COP0: begin
				if (ins[25:21] == 5'd0) begin
					r.control.flags.copRead = 1'b1;
					r.control.flags.regWrite = 1'b1;
					r.control.destReg = ins[20:16];
				end else if (ins[25:21] == 5'd4) begin
					r.control.flags.copWrite = 1'b1;
					r.control.destReg = ins[15:11];
				end
			end
			default: r.control = '0;
		endcase
		r.control.iCacheFlush = w.copEn && w.num == `COP_CACHE && w.data[0];
		r.control.dCacheFlush = w.copEn && w.num == `COP_CACHE && w.data[1];
		r.rs = readShadow(ins[25:21], w);
		r.rt = readShadow(ins[20:16], w);
		r.cop = ins[15:11] == `COP_CAUSE ? shCause : ins[15:11] == `COP_STATUS ? shStatus
			: ins[15:11] == `COP_EPC ? shEpc : '0;
		r.exception = (irqIn && !shStatus[0])
			|| (op == OP_SPECIAL && (fn == FN_SYSCALL || fn == FN_BREAK));
		pc4 = shDecodePc + 32'd4;
		if (r.control.flags.jumpReg)
			r.target = r.rs;
		else if (op == OP_J || op == OP_JAL)
			r.target = {pc4[31:28], ins[25:0], 2'b00};
		else
			r.target = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
		case (r.control.branchType)
			BR_EQ:   taken = r.rs == r.rt;
			BR_NE:   taken = r.rs != r.rt;
			BR_LEZ:  taken = $signed(r.rs) <= 0;
			BR_GTZ:  taken = $signed(r.rs) > 0;
			BR_LTZ:  taken = $signed(r.rs) < 0;
			BR_GEZ:  taken = $signed(r.rs) >= 0;
			BR_JUMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		if (stl || clr)
			r.nextPc = shNextPc;
		else if (r.exception)
			r.nextPc = `EXCEPTION_VECTOR;
		else
			r.nextPc = taken ? r.target : shNextPc + 32'd4;
		return r;
	endfunction

	// drive one cycle, predict, advance shadow, wait for the next drive point
	task automatic issue(word_t ins, logic stl, logic clr, logic irqIn, irqNum_t irqNo,
			wbWrite_t w);
		result_t r;
		logic irqTaken;
		logic accept;
		instr = ins;
		stall = stl;
		clear = clr;
		irq = irqIn;
		irqNumber = irqNo;
		wb = w;
		r = expectDecode(ins, stl, clr, irqIn, w);
		expDe = r.control;
		expExc = r.exception;
		if (!stl) begin
			expNext.target = r.target;
			if (clr || r.exception) begin
				expNext.instr = '0;
				expNext.control = '0;
				expNext.rs = '0;
				expNext.rt = '0;
				expNext.cop = '0;
			end else begin
				expNext.instr = ins;
				expNext.control = r.control;
				expNext.rs = r.rs;
				expNext.rt = r.rt;
				expNext.cop = r.cop;
			end
		end
		expNext.nextPc = r.nextPc;
		irqTaken = irqIn && !shStatus[0];
		accept = r.exception && !stl && !clr;
		if (w.regEn && w.num != 5'd0)
			shRegs[w.num] = w.data;
		if (w.copEn && w.num == `COP_STATUS)
			shStatus = w.data;
		if (accept) begin
			if (irqTaken)
				shCause = {shPrevBranch, 15'b0, irqNo, 10'b0};
			else if (ins[5:0] == FN_BREAK)
				shCause = {shPrevBranch, 26'b0, 4'd9, 1'b0};
			else
				shCause = {shPrevBranch, 26'b0, 4'd8, 1'b0};
			shStatus[0] = 1'b1;
			shEpc = shPrevBranch ? shDecodePc - 32'd4 : shDecodePc;
		end
		if (!stl && !clr) begin
			shPrevBranch = !r.exception && r.control.branchType != BR_NONE;
			shDecodePc = shNextPc;
			shNextPc = r.nextPc;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic checkWord(string name, word_t got, word_t exp);
		checkCount++;
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	// Ex checks begin after the first edge
	always @(posedge clk) begin
		expNow <= expNext;
		checkNow <= 1'b1;
	end

	// sampled mid-cycle away from both drive and edge
	always @(negedge clk) begin
		if (checkNow) begin
			checkWord("instrEx", dutEx.instr, expNow.instr);
			checkWord("controlEx", {1'b0, dutEx.control}, {1'b0, expNow.control});
			checkWord("rsEx", dutEx.rs, expNow.rs);
			checkWord("rtEx", dutEx.rt, expNow.rt);
			checkWord("copEx", dutEx.cop, expNow.cop);
			checkWord("branchTargetEx", dutEx.target, expNow.target);
			checkWord("nextPc", dutEx.nextPc, expNow.nextPc);
		end
		if (deCheck) begin
			checkWord("controlDe", {1'b0, controlDe}, {1'b0, expDe});
			checkWord("exception", {31'b0, exception}, {31'b0, expExc});
		end
	end

	// limit far above the roughly 230 cycles of stimulus
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= 2000) begin
			$display("Timeout: run did not finish within 2000 cycles");
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		stall = 1'b0;
		clear = 1'b0;
		irq = 1'b0;
		irqNumber = '0;
		instr = '0;
		wb = '0;
		lfsrState = 32'h8ad4_c064;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		checkNow = 1'b0;
		deCheck = 1'b0;
		expNext = '0;
		expNext.nextPc = `RESET_ADDRESS;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		shRegs[29] = `STACK_INIT;
		shCause = '0;
		shStatus = '0;
		shEpc = '0;
		shDecodePc = `RESET_ADDRESS;
		shNextPc = `RESET_ADDRESS;
		shPrevBranch = 1'b0;
		deCheck = 1'b1;

		// $sp after reset, then a full fill and random reads
		issue(encodeR(FN_ADDU, 5'd29, 5'd0, 5'd5), 0, 0, 0, '0, '0);
		for (int n = 1; n < 32; n++)
			issue('0, 0, 0, 0, '0, makeRegWrite(5'(n), randomBits(32)));
		repeat (40)
			issue(encodeR(FN_ADDU, 5'(randomBits(5)), 5'(randomBits(5)), 5'(randomBits(5))),
				0, 0, 0, '0, randomBits(1) != 0
					? makeRegWrite(5'(randomBits(5)), randomBits(32)) : '0);

		// same-cycle writes to the register being read, $zero first
		for (int n = 0; n < 5; n++)
			issue(encodeR(FN_ADDU, 5'(n), 5'(n + 16), 5'd7), 0, 0, 0, '0,
				makeRegWrite(5'(n + 16 * (n % 2)), randomBits(32)));

		// every opcode and funct decoded before the branch types
		foreach (opList[i])
			repeat (3) issue(makeInstr(opList[i]), 0, 0, 0, '0, '0);
		foreach (fnList[i])
			issue(encodeR(fnList[i], 5'(randomBits(5)), 5'(randomBits(5)), 5'(randomBits(5))),
				0, 0, 0, '0, '0);
		foreach (brList[i])
			repeat (6) issue(makeInstr(brList[i]), 0, 0, 0, '0, '0);

		// stall and clear mixed in
		repeat (24)
			issue(makeInstr(opList[randomBits(4)]), randomBits(1) != 0,
				randomBits(2) == 0, 0, '0, '0);

		// exceptions and cop0 reads
		issue(encodeR(FN_SYSCALL, 5'd0, 5'd0, 5'd0), 1, 0, 0, '0, '0);  // held by stall
		issue(encodeR(FN_SYSCALL, 5'd0, 5'd0, 5'd0), 0, 0, 0, '0, '0);
		for (int n = 0; n < 3; n++)
			issue(encodeMfc0(5'd8, 5'(n)), 0, 0, 0, '0, '0);
		issue(encodeR(FN_ADDU, 5'd1, 5'd2, 5'd3), 0, 0, 1, 6'h2a, '0);  // masked irq
		issue('0, 0, 0, 0, '0, makeCopWrite(`COP_STATUS, '0));
		issue({OP_BEQ, 5'd0, 5'd0, 16'h0010}, 0, 0, 0, '0, '0);
		issue(encodeR(FN_BREAK, 5'd0, 5'd0, 5'd0), 0, 0, 0, '0, '0);  // in delay slot
		for (int n = 0; n < 3; n++)
			issue(encodeMfc0(5'd9, 5'(n)), 0, 0, 0, '0, '0);
		issue('0, 0, 0, 0, '0, makeCopWrite(`COP_STATUS, '0));
		issue(encodeR(FN_OR, 5'd4, 5'd5, 5'd6), 0, 0, 1, 6'(randomBits(6)), '0);
		for (int n = 0; n < 3; n++)
			issue(encodeMfc0(5'd10, 5'(n)), 0, 0, 0, '0, '0);

		// cache flush requests from cop0 register 3
		repeat (8)
			issue(makeInstr(OP_ADDIU), 0, 0, 0, '0,
				makeCopWrite(`COP_CACHE, randomBits(2)));

		deCheck = 1'b0;
		@(negedge clk);
		#1;
		$display("Checks: %0d, mismatches: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end
endmodule

/* include/decode_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage configuration
// fixed addresses, stack start and cop0 register numbers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// fetch addresses
`define RESET_ADDRESS    32'h0000_0000
`define EXCEPTION_VECTOR 32'h0000_0080  // handler entry

`define STACK_INIT       32'h0078_0000  // initial $sp

// coprocessor 0 register numbers
`define COP_CAUSE  5'd0
`define COP_STATUS 5'd1
`define COP_EPC    5'd2
`define COP_CACHE  5'd3  // write-only, bit 0 icache, bit 1 dcache

`endif

/* source/branchUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch unit
// branch resolve, delay slot tracking, fetch pc
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "decode_config.svh"

module branchUnit
	import isaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     clear,
	input  logic     exception,
	input  word_t    instr,
	input  control_t control,
	input  word_t    rsVal,
	input  word_t    rtVal,
	output word_t    branchTarget,
	output word_t    nextPc,
	output word_t    epcCandidate,
	output logic     inDelaySlot
);
	word_t decodePc;  // address of instr in decode
	word_t pcPlus4;
	word_t offsetTarget;
	word_t jumpTarget;
	opcode_t opcode;
	logic taken;
	logic prevBranch;

	assign opcode = opcodeOf(instr);
	assign pcPlus4 = decodePc + 32'd4;
	assign offsetTarget = pcPlus4 + {{14{instr[15]}}, immOf(instr), 2'b00};
	assign jumpTarget = {pcPlus4[31:28], indexOf(instr), 2'b00};  // same 256MB region

	always_comb begin
		if (control.flags.jumpReg)
			branchTarget = rsVal;
		else if (opcode == OP_J || opcode == OP_JAL)
			branchTarget = jumpTarget;
		else
			branchTarget = offsetTarget;
	end

	// signed compares against zero use the sign bit
	always_comb begin
		case (control.branchType)
			BR_EQ:   taken = rsVal == rtVal;
			BR_NE:   taken = rsVal != rtVal;
			BR_LEZ:  taken = rsVal[31] || rsVal == '0;
			BR_GTZ:  taken = !rsVal[31] && rsVal != '0;
			BR_LTZ:  taken = rsVal[31];
			BR_GEZ:  taken = !rsVal[31];
			BR_JUMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign inDelaySlot = prevBranch;
	assign epcCandidate = prevBranch ? decodePc - 32'd4 : decodePc;  // restart at the branch

	always_ff @(posedge clk) begin
		if (reset) begin
			nextPc <= `RESET_ADDRESS;
			decodePc <= `RESET_ADDRESS;
			prevBranch <= 1'b0;
		end else if (!stall && !clear) begin
			decodePc <= nextPc;
			prevBranch <= !exception && control.branchType != BR_NONE;
			if (exception)
				nextPc <= `EXCEPTION_VECTOR;
			else if (taken)
				nextPc <= branchTarget;
			else
				nextPc <= nextPc + 32'd4;
		end
	end
endmodule

/* source/cop0Unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coprocessor 0
// cause, status, epc, exception detect, cache flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "decode_config.svh"

module cop0Unit
	import isaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     clear,
	input  logic     irq,
	input  irqNum_t  irqNumber,
	input  word_t    instr,
	input  wbWrite_t wb,
	input  word_t    epcCandidate,
	input  logic     inDelaySlot,
	output logic     exception,
	output logic     iCacheFlush,
	output logic     dCacheFlush,
	output word_t    copData
);
	word_t cause;
	word_t status;  // bit 0 set masks irq
	word_t epc;
	logic isSpecial;
	logic syscall;
	logic breakInstr;
	logic irqTaken;
	logic accept;
	logic cacheWrite;

	assign isSpecial = opcodeOf(instr) == OP_SPECIAL;
	assign syscall = isSpecial && functOf(instr) == FN_SYSCALL;
	assign breakInstr = isSpecial && functOf(instr) == FN_BREAK;
	assign irqTaken = irq && !status[0];
	assign exception = irqTaken || syscall || breakInstr;
	assign accept = exception && !stall && !clear;

	// flush requests live for the write-back cycle only
	assign cacheWrite = wb.copEn && wb.num == `COP_CACHE;
	assign iCacheFlush = cacheWrite && wb.data[0];
	assign dCacheFlush = cacheWrite && wb.data[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			cause <= '0;
			status <= '0;  // interrupts enabled
			epc <= '0;
		end else begin
			if (wb.copEn && wb.num == `COP_STATUS)
				status <= wb.data;
			if (accept) begin
				if (irqTaken)
					cause <= {inDelaySlot, 15'b0, irqNumber, 10'b0};
				else if (breakInstr)
					cause <= {inDelaySlot, 26'b0, 4'd9, 1'b0};
				else
					cause <= {inDelaySlot, 26'b0, 4'd8, 1'b0};  // syscall
				status[0] <= 1'b1;  // mask further irqs
				epc <= epcCandidate;
			end
		end
	end

	// mfc0 source picked by rd
	always_comb begin
		case (rdOf(instr))
			`COP_CAUSE:  copData = cause;
			`COP_STATUS: copData = status;
			`COP_EPC:    copData = epc;
			default:     copData = '0;
		endcase
	end
endmodule

/* source/decodeStage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage top
// decode, operand read, cop0, branch, execute register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module decodeStage
	import isaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     clear,
	input  logic     irq,
	input  irqNum_t  irqNumber,
	input  word_t    instr,
	input  wbWrite_t wb,
	output logic     exception,
	output control_t controlDe,
	output word_t    instrEx,
	output control_t controlEx,
	output word_t    rsEx,
	output word_t    rtEx,
	output word_t    copEx,
	output word_t    branchTargetEx,
	output word_t    nextPc
);
	control_t decoded;  // flush bits still zero here
	word_t rsVal;
	word_t rtVal;
	word_t copData;
	word_t branchTarget;
	word_t epcCandidate;
	logic inDelaySlot;
	logic iCacheFlush;
	logic dCacheFlush;

	instrDecoder i_decoder (
		.instr   (instr),
		.control (decoded)
	);

	registerFile i_regFile (
		.clk   (clk),
		.reset (reset),
		.rsNum (rsOf(instr)),
		.rtNum (rtOf(instr)),
		.wb    (wb),
		.rsVal (rsVal),
		.rtVal (rtVal)
	);

	cop0Unit i_cop0 (
		.clk          (clk),
		.reset        (reset),
		.stall        (stall),
		.clear        (clear),
		.irq          (irq),
		.irqNumber    (irqNumber),
		.instr        (instr),
		.wb           (wb),
		.epcCandidate (epcCandidate),
		.inDelaySlot  (inDelaySlot),
		.exception    (exception),
		.iCacheFlush  (iCacheFlush),
		.dCacheFlush  (dCacheFlush),
		.copData      (copData)
	);

	branchUnit i_branch (
		.clk          (clk),
		.reset        (reset),
		.stall        (stall),
		.clear        (clear),
		.exception    (exception),
		.instr        (instr),
		.control      (decoded),
		.rsVal        (rsVal),
		.rtVal        (rtVal),
		.branchTarget (branchTarget),
		.nextPc       (nextPc),
		.epcCandidate (epcCandidate),
		.inDelaySlot  (inDelaySlot)
	);

	// flush requests come from write-back, not from this instr
	always_comb begin
		controlDe = decoded;
		controlDe.iCacheFlush = iCacheFlush;
		controlDe.dCacheFlush = dCacheFlush;
	end

	// execute register, stall beats clear beats advance
	always_ff @(posedge clk) begin
		if (reset) begin
			instrEx <= '0;
			controlEx <= '0;
			rsEx <= '0;
			rtEx <= '0;
			copEx <= '0;
			branchTargetEx <= '0;
		end else if (!stall) begin
			branchTargetEx <= branchTarget;
			if (clear || exception) begin
				instrEx <= '0;  // bubble
				controlEx <= '0;
				rsEx <= '0;
				rtEx <= '0;
				copEx <= '0;
			end else begin
				instrEx <= instr;
				controlEx <= controlDe;
				rsEx <= rsVal;
				rtEx <= rtVal;
				copEx <= copData;
			end
		end
	end
endmodule

/* source/instrDecoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder
// instruction word to control word, no flush bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module instrDecoder
	import isaPkg::*, pipePkg::*;
(
	input  word_t    instr,
	output control_t control
);
	opcode_t opcode;
	funct_t funct;

	assign opcode = opcodeOf(instr);
	assign funct = functOf(instr);

	always_comb begin
		control = '0;  // unknown encodings stay all zero
		case (opcode)
			OP_SPECIAL: begin
				control.destReg = rdOf(instr);
				control.flags.regWrite = 1'b1;
				case (funct)
					FN_ADDU: control.aluOp = ALU_ADD;
					FN_SUBU: control.aluOp = ALU_SUB;
					FN_AND:  control.aluOp = ALU_AND;
					FN_OR:   control.aluOp = ALU_OR;
					FN_SLT:  control.aluOp = ALU_SLT;
					FN_SLL:  control.aluOp = ALU_SLL;
					FN_JR: begin
						control.flags.regWrite = 1'b0;  // no link
						control.flags.jumpReg = 1'b1;
						control.branchType = BR_JUMP;
					end
					FN_JALR: begin
						control.flags.jumpReg = 1'b1;
						control.flags.link = 1'b1;
						control.branchType = BR_JUMP;
					end
					default: control = '0;  // syscall and break go to cop0
				endcase
			end
			OP_REGIMM: begin
				control.flags.signExt = 1'b1;
				if (rtOf(instr) == RT_BLTZ)
					control.branchType = BR_LTZ;
				else if (rtOf(instr) == RT_BGEZ)
					control.branchType = BR_GEZ;
				else
					control = '0;
			end
			OP_J: control.branchType = BR_JUMP;
			OP_JAL: begin
				control.branchType = BR_JUMP;
				control.flags.link = 1'b1;
				control.flags.regWrite = 1'b1;
				control.destReg = 5'd31;  // $ra
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				control.flags.signExt = 1'b1;
				case (opcode)
					OP_BEQ:  control.branchType = BR_EQ;
					OP_BNE:  control.branchType = BR_NE;
					OP_BLEZ: control.branchType = BR_LEZ;
					default: control.branchType = BR_GTZ;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
				control.flags.regWrite = 1'b1;
				control.flags.aluSrcImm = 1'b1;
				control.destReg = rtOf(instr);
				case (opcode)
					OP_SLTI: control.aluOp = ALU_SLT;
					OP_ANDI: control.aluOp = ALU_AND;  // zero extended
					OP_ORI:  control.aluOp = ALU_OR;
					OP_LUI:  control.aluOp = ALU_LUI;
					default: control.aluOp = ALU_ADD;  // addiu and lw address
				endcase
				control.flags.signExt = (opcode == OP_ADDIU) || (opcode == OP_SLTI)
					|| (opcode == OP_LW);
				control.flags.memRead = (opcode == OP_LW);
			end
			OP_SW: begin
				control.flags.memWrite = 1'b1;
				control.flags.aluSrcImm = 1'b1;
				control.flags.signExt = 1'b1;
				control.aluOp = ALU_ADD;
			end
			OP_COP0: begin
				if (rsOf(instr) == RS_MFC0) begin
					control.flags.copRead = 1'b1;
					control.flags.regWrite = 1'b1;
					control.destReg = rtOf(instr);
				end else if (rsOf(instr) == RS_MTC0) begin
					control.flags.copWrite = 1'b1;
					control.destReg = rdOf(instr);  // cop register for write-back
				end
			end
			default: control = '0;
		endcase
	end
endmodule

/* source/isaPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction set encoding
// word and field types, opcodes, function codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isaPkg;
	localparam int WORD_WIDTH = 32;
	localparam int OPCODE_WIDTH = 6;
	localparam int FUNCT_WIDTH = 6;
	localparam int REG_NUM_WIDTH = 5;
	localparam int IMM_WIDTH = 16;
	localparam int INDEX_WIDTH = 26;  // j/jal target index

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [REG_NUM_WIDTH-1:0] regNum_t;
	typedef logic [IMM_WIDTH-1:0] imm_t;
	typedef logic [INDEX_WIDTH-1:0] jumpIndex_t;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_SPECIAL = 6'h00,
		OP_REGIMM  = 6'h01,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_BLEZ    = 6'h06,
		OP_BGTZ    = 6'h07,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_COP0    = 6'h10,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	typedef enum logic [FUNCT_WIDTH-1:0] {
		FN_SLL     = 6'h00,
		FN_JR      = 6'h08,
		FN_JALR    = 6'h09,
		FN_SYSCALL = 6'h0c,
		FN_BREAK   = 6'h0d,
		FN_ADDU    = 6'h21,
		FN_SUBU    = 6'h23,
		FN_AND     = 6'h24,
		FN_OR      = 6'h25,
		FN_SLT     = 6'h2a
	} funct_t;

	// regimm codes in rt, cop0 codes in rs
	localparam regNum_t RT_BLTZ = 5'd0;
	localparam regNum_t RT_BGEZ = 5'd1;
	localparam regNum_t RS_MFC0 = 5'd0;
	localparam regNum_t RS_MTC0 = 5'd4;

	// field extraction
	function automatic opcode_t opcodeOf(word_t w);
		return opcode_t'(w[31:26]);
	endfunction

	function automatic funct_t functOf(word_t w);
		return funct_t'(w[5:0]);
	endfunction

	function automatic regNum_t rsOf(word_t w);
		return w[25:21];
	endfunction

	function automatic regNum_t rtOf(word_t w);
		return w[20:16];
	endfunction

	function automatic regNum_t rdOf(word_t w);
		return w[15:11];
	endfunction

	function automatic imm_t immOf(word_t w);
		return w[15:0];
	endfunction

	function automatic jumpIndex_t indexOf(word_t w);
		return w[25:0];
	endfunction
endpackage

/* source/pipePkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline types
// control word and write-back bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pipePkg;
	import isaPkg::*;

	typedef logic [5:0] irqNum_t;

	typedef enum logic [4:0] {
		ALU_NONE = 5'd0,
		ALU_ADD  = 5'd1,
		ALU_SUB  = 5'd2,
		ALU_AND  = 5'd3,
		ALU_OR   = 5'd4,
		ALU_SLT  = 5'd5,
		ALU_SLL  = 5'd6,
		ALU_LUI  = 5'd7   // imm into upper half
	} aluOp_t;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LEZ  = 3'd3,
		BR_GTZ  = 3'd4,
		BR_LTZ  = 3'd5,
		BR_GEZ  = 3'd6,
		BR_JUMP = 3'd7   // j, jal, jr, jalr
	} branchType_t;

	// 16 flag bits, top ones spare
	typedef struct packed {
		logic       regWrite;
		logic       memRead;
		logic       memWrite;
		logic       aluSrcImm;  // operand b from immediate
		logic       signExt;
		logic       link;       // write return address
		logic       jumpReg;
		logic       copRead;
		logic       copWrite;
		logic [6:0] reserved;
	} flags_t;

	// 31 bits, same layout as execute expects
	typedef struct packed {
		logic        iCacheFlush;
		logic        dCacheFlush;
		flags_t      flags;
		aluOp_t      aluOp;
		branchType_t branchType;
		regNum_t     destReg;
	} control_t;

	// write-back into decode
	typedef struct packed {
		logic    regEn;
		logic    copEn;
		regNum_t num;
		word_t   data;
	} wbWrite_t;
endpackage

/* source/registerFile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer register file
// 31 x 32, $zero fixed, bypass from write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "decode_config.svh"

module registerFile
	import isaPkg::*, pipePkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  regNum_t  rsNum,
	input  regNum_t  rtNum,
	input  wbWrite_t wb,
	output word_t    rsVal,
	output word_t    rtVal
);
	word_t regs [31:1];  // no storage for $zero
	logic writeEn;

	// zero register first, then bypass, then storage
	function automatic word_t readPort(regNum_t num, word_t stored, wbWrite_t w);
		if (num == '0)
			return '0;
		if (w.regEn && w.num == num)
			return w.data;  // same-cycle write
		return stored;
	endfunction

	assign writeEn = wb.regEn && (wb.num != '0);

	always_ff @(posedge clk) begin
		if (writeEn)
			regs[wb.num] <= wb.data;
		if (reset)
			regs[29] <= `STACK_INIT;  // $sp
	end

	assign rsVal = readPort(rsNum, regs[rsNum], wb);
	assign rtVal = readPort(rtNum, regs[rtNum], wb);
endmodule

/* vlog.f */
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/cop0Unit.sv
source/branchUnit.sv
source/decodeStage.sv
dv/decodeStageSva.sv
dv/decodeStageTb.sv
